/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_c16
FILELIST  ?= c16.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_MSG  ?= All tests passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, fail unless it passes"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* c16.f */
c16_pkg.sv
c16_registers.sv
c16_fetcher.sv
c16_queue.sv
c16_decoder.sv
c16_executor.sv
c16_top.sv
tb_c16_checker.sv
tb_c16.sv

/* c16_decoder.sv */
module c16_decoder (
   input  logic                 clk,
   input  logic                 rst_n,
   input  c16_pkg::fetch_word_t fetch_word,
   input  c16_pkg::read_rsp_t   rsp_first,
   input  c16_pkg::read_rsp_t   rsp_second,
   output c16_pkg::read_req_t   req_first,
   output c16_pkg::read_req_t   req_second,
   output c16_pkg::issue_slot_t slot_first,
   output c16_pkg::issue_slot_t slot_second,
   output logic                 fetch_stall
);
   import c16_pkg::*;

   word_t       first_inst;
   word_t       second_inst;
   logic        consume_one;
   issue_slot_t decoded_second;
   logic        first_writes;
   logic        second_reads;

   c16_queue queue_i (
      .clk         (clk),
      .rst_n       (rst_n),
      .fetch_word  (fetch_word),
      .consume_one (consume_one),
      .first_inst  (first_inst),
      .second_inst (second_inst),
      .fetch_stall (fetch_stall)
   );

   //////////////////////////////
   // Opcode decode
   //////////////////////////////

   // Register forms read rt as the second operand
   function automatic logic uses_rt(input word_t inst);
      opcode_e op;
      op = inst_opcode(inst);
      return (op == op_add) || (op == op_sub);
   endfunction

   function automatic issue_slot_t decode(input word_t inst, input read_rsp_t rsp);
      issue_slot_t s;
      s = nop_slot;
      s.dest = inst_rd(inst);
      s.arg_0 = rsp.rs;
      case (inst_opcode(inst))
         op_addi: begin
            s.op = alu_add;
            s.arg_1 = inst_imm(inst);
         end
         op_add: begin
            s.op = alu_add;
            s.arg_1 = rsp.rt;
         end
         op_subi: begin
            s.op = alu_sub;
            s.arg_1 = inst_imm(inst);
         end
         op_sub: begin
            s.op = alu_sub;
            s.arg_1 = rsp.rt;
         end
         default: begin
            s = nop_slot;
         end
      endcase
      return s;
   endfunction

   assign req_first  = '{rs: inst_rs(first_inst), rt: inst_rt(first_inst)};
   assign req_second = '{rs: inst_rs(second_inst), rt: inst_rt(second_inst)};

   assign slot_first     = decode(first_inst, rsp_first);
   assign decoded_second = decode(second_inst, rsp_second);

   //////////////////////////////
   // Intra-pair hazard
   //////////////////////////////

   // Writes to the zero register never create a dependency
   assign first_writes = (slot_first.op != alu_nop) && (slot_first.dest != zero_reg);

   assign second_reads = (decoded_second.op != alu_nop)
                         && ((inst_rs(second_inst) == slot_first.dest)
                             || (uses_rt(second_inst)
                                 && inst_rt(second_inst) == slot_first.dest));

   // Split pair, second halfword waits in the queue
   assign consume_one = first_writes && second_reads;
   assign slot_second = consume_one ? nop_slot : decoded_second;

endmodule

/* c16_executor.sv */
module c16_executor (
   input  logic                 clk,
   input  logic                 rst_n,
   input  c16_pkg::issue_slot_t slot,
   output c16_pkg::write_port_t wb
);
   import c16_pkg::*;

   issue_slot_t slot_q;
   word_t       result;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         slot_q <= nop_slot;
      end else begin
         slot_q <= slot;
      end
   end

   // Wraps modulo 2^16
   always_comb begin
      case (slot_q.op)
         alu_add: result = slot_q.arg_0 + slot_q.arg_1;
         alu_sub: result = slot_q.arg_0 - slot_q.arg_1;
         default: result = '0;
      endcase
   end

   assign wb.en    = (slot_q.op == alu_add || slot_q.op == alu_sub)
                     && (slot_q.dest != zero_reg);
   assign wb.dest  = slot_q.dest;
   assign wb.value = result;

endmodule

/* c16_fetcher.sv */
module c16_fetcher #(
   parameter int unsigned pc_width = c16_pkg::pc_width
) (
   input  logic                clk,
   input  logic                rst_n,
   input  logic                stall,
   output logic [pc_width-1:0] fetch_addr
);

   logic [pc_width-1:0] addr_q;

   // One word per cycle, held while the queue is full
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         addr_q <= '0;
      end else if (!stall) begin
         addr_q <= addr_q + 1'b1;
      end
   end

   assign fetch_addr = addr_q;

endmodule

/* c16_pkg.sv */
package c16_pkg;

   //////////////////////////////
   // Widths and basic types
   //////////////////////////////

   localparam int unsigned pc_width = 16;

   typedef logic [15:0] word_t;
   typedef logic [31:0] fetch_word_t;
   typedef logic [2:0]  reg_idx_t;

   // Hardwired zero register
   localparam reg_idx_t zero_reg = 3'd7;

   // Bits 15..11 of an instruction, anything else is a no-op
   typedef enum logic [4:0] {
      op_addi = 5'd0,
      op_add  = 5'd1,
      op_subi = 5'd2,
      op_sub  = 5'd3
   } opcode_e;

   typedef enum logic [1:0] {
      alu_nop = 2'd0,
      alu_add = 2'd1,
      alu_sub = 2'd2
   } alu_op_e;

   //////////////////////////////
   // Pipeline structs
   //////////////////////////////

   typedef struct packed {
      alu_op_e  op;
      word_t    arg_0;
      word_t    arg_1;
      reg_idx_t dest;
   } issue_slot_t;

   typedef struct packed {
      logic     en;
      reg_idx_t dest;
      word_t    value;
   } write_port_t;

   typedef struct packed {
      reg_idx_t rs;
      reg_idx_t rt;
   } read_req_t;

   typedef struct packed {
      word_t rs;
      word_t rt;
   } read_rsp_t;

   localparam issue_slot_t nop_slot = '{op: alu_nop, arg_0: '0, arg_1: '0, dest: '0};

   //////////////////////////////
   // Instruction fields
   //////////////////////////////

   function automatic opcode_e inst_opcode(input word_t inst);
      return opcode_e'(inst[15:11]);
   endfunction

   function automatic reg_idx_t inst_rd(input word_t inst);
      return inst[10:8];
   endfunction

   function automatic reg_idx_t inst_rs(input word_t inst);
      return inst[7:5];
   endfunction

   function automatic reg_idx_t inst_rt(input word_t inst);
      return inst[2:0];
   endfunction

   // imm5 sign-extended to a full word
   function automatic word_t inst_imm(input word_t inst);
      return {{11{inst[4]}}, inst[4:0]};
   endfunction

endpackage

/* c16_queue.sv */
module c16_queue (
   input  logic                 clk,
   input  logic                 rst_n,
   input  c16_pkg::fetch_word_t fetch_word,
   input  logic                 consume_one,
   output c16_pkg::word_t       first_inst,
   output c16_pkg::word_t       second_inst,
   output logic                 fetch_stall
);
   import c16_pkg::*;

   logic [1:0]  count_q;
   word_t [1:0] entry_q;

   // Oldest halfword in avail[0]
   word_t [2:0] avail;
   logic [1:0]  avail_count;
   logic [1:0]  issued;
   logic [1:0]  count_next;

   always_comb begin
      avail = '0;
      case (count_q)
         2'd0: begin
            avail[0]    = fetch_word[15:0];
            avail[1]    = fetch_word[31:16];
            avail_count = 2'd2;
         end
         2'd1: begin
            avail[0]    = entry_q[0];
            avail[1]    = fetch_word[15:0];
            avail[2]    = fetch_word[31:16];
            avail_count = 2'd3;
         end
         default: begin
            // Full, the fetched word is not taken
            avail[0]    = entry_q[0];
            avail[1]    = entry_q[1];
            avail_count = 2'd2;
         end
      endcase
   end

   assign issued     = consume_one ? 2'd1 : 2'd2;
   assign count_next = avail_count - issued;

   assign first_inst  = avail[0];
   assign second_inst = avail[1];
   assign fetch_stall = (count_q == 2'd2);

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         count_q <= 2'd0;
      end else begin
         count_q <= count_next;
      end
   end

   // Leftovers shift down in program order
   // Two only remain after a split with three available
   always_ff @(posedge clk) begin
      entry_q[0] <= avail[issued];
      entry_q[1] <= avail[2];
   end

endmodule

/* c16_registers.sv */
module c16_registers (
   input  logic                 clk,
   input  logic                 rst_n,
   input  c16_pkg::read_req_t   req_first,
   input  c16_pkg::read_req_t   req_second,
   input  c16_pkg::reg_idx_t    dbg_addr,
   input  c16_pkg::write_port_t wb_first,
   input  c16_pkg::write_port_t wb_second,
   output c16_pkg::read_rsp_t   rsp_first,
   output c16_pkg::read_rsp_t   rsp_second,
   output c16_pkg::word_t       dbg_value
);
   import c16_pkg::*;

   word_t [7:0] regs;

   // Stored value, overridden by this cycle's writes, second lane last
   function automatic word_t read_port(
      input reg_idx_t    idx,
      input word_t [7:0] file,
      input write_port_t wa,
      input write_port_t wb
   );
      word_t value;
      value = file[idx];
      if (wa.en && wa.dest == idx) begin
         value = wa.value;
      end
      if (wb.en && wb.dest == idx) begin
         value = wb.value;
      end
      if (idx == zero_reg) begin
         value = '0;
      end
      return value;
   endfunction

   always_comb begin
      rsp_first.rs  = read_port(req_first.rs, regs, wb_first, wb_second);
      rsp_first.rt  = read_port(req_first.rt, regs, wb_first, wb_second);
      rsp_second.rs = read_port(req_second.rs, regs, wb_first, wb_second);
      rsp_second.rt = read_port(req_second.rt, regs, wb_first, wb_second);
      dbg_value     = read_port(dbg_addr, regs, wb_first, wb_second);
   end

   // Second lane written last so it wins on a shared destination
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         regs <= '0;
      end else begin
         if (wb_first.en && wb_first.dest != zero_reg) begin
            regs[wb_first.dest] <= wb_first.value;
         end
         if (wb_second.en && wb_second.dest != zero_reg) begin
            regs[wb_second.dest] <= wb_second.value;
         end
      end
   end

endmodule

/* c16_top.sv */
module c16_top #(
   parameter int unsigned pc_width = c16_pkg::pc_width
) (
   input  logic                 clk,
   input  logic                 rst_n,
   input  c16_pkg::fetch_word_t fetch_word,
   input  c16_pkg::reg_idx_t    dbg_addr,
   output logic [pc_width-1:0]  fetch_addr,
   output logic                 fetch_stall,
   output c16_pkg::write_port_t wb_first,
   output c16_pkg::write_port_t wb_second,
   output c16_pkg::word_t       dbg_value
);
   import c16_pkg::*;

   read_req_t   req_first;
   read_req_t   req_second;
   read_rsp_t   rsp_first;
   read_rsp_t   rsp_second;
   issue_slot_t slot_first;
   issue_slot_t slot_second;

   c16_fetcher #(
      .pc_width (pc_width)
   ) fetcher_i (
      .clk        (clk),
      .rst_n      (rst_n),
      .stall      (fetch_stall),
      .fetch_addr (fetch_addr)
   );

   c16_decoder decoder_i (
      .clk         (clk),
      .rst_n       (rst_n),
      .fetch_word  (fetch_word),
      .rsp_first   (rsp_first),
      .rsp_second  (rsp_second),
      .req_first   (req_first),
      .req_second  (req_second),
      .slot_first  (slot_first),
      .slot_second (slot_second),
      .fetch_stall (fetch_stall)
   );

   c16_registers registers_i (
      .clk        (clk),
      .rst_n      (rst_n),
      .req_first  (req_first),
      .req_second (req_second),
      .dbg_addr   (dbg_addr),
      .wb_first   (wb_first),
      .wb_second  (wb_second),
      .rsp_first  (rsp_first),
      .rsp_second (rsp_second),
      .dbg_value  (dbg_value)
   );

   // Two identical lanes, second one wins on write conflicts
   c16_executor executor_first_i (
      .clk   (clk),
      .rst_n (rst_n),
      .slot  (slot_first),
      .wb    (wb_first)
   );

   c16_executor executor_second_i (
      .clk   (clk),
      .rst_n (rst_n),
      .slot  (slot_second),
      .wb    (wb_second)
   );

endmodule

/* tb_c16.sv */
module tb_c16;
   timeunit 1ns;
   timeprecision 1ps;
   import c16_pkg::*;

   localparam int          prog_depth = 512;
   localparam int          addr_width = 16;
   localparam logic [31:0] seed       = 32'h8908_4311;

   logic                  clk;
   logic                  rst_n;
   fetch_word_t           fetch_word;
   reg_idx_t              dbg_addr;
   logic [addr_width-1:0] fetch_addr;
   logic                  fetch_stall;
   write_port_t           wb_first;
   write_port_t           wb_second;
   word_t                 dbg_value;

   word_t       prog [prog_depth];
   int          prog_len;
   logic        test_start;
   logic        sweep_on;
   logic        trace_done;
   int unsigned stall_cycles;
   int unsigned errors;
   int unsigned tests_run;
   int unsigned tests_failed;
   logic [31:0] rng;
   time         budget_ns;

   c16_top #(
      .pc_width (addr_width)
   ) c16_top_i (
      .clk         (clk),
      .rst_n       (rst_n),
      .fetch_word  (fetch_word),
      .dbg_addr    (dbg_addr),
      .fetch_addr  (fetch_addr),
      .fetch_stall (fetch_stall),
      .wb_first    (wb_first),
      .wb_second   (wb_second),
      .dbg_value   (dbg_value)
   );

   tb_c16_checker #(
      .prog_depth (prog_depth),
      .addr_width (addr_width)
   ) checker_i (
      .clk          (clk),
      .rst_n        (rst_n),
      .test_start   (test_start),
      .prog         (prog),
      .prog_len     (prog_len),
      .fetch_addr   (fetch_addr),
      .fetch_stall  (fetch_stall),
      .wb_first     (wb_first),
      .wb_second    (wb_second),
      .sweep_on     (sweep_on),
      .dbg_addr     (dbg_addr),
      .dbg_value    (dbg_value),
      .trace_done   (trace_done),
      .stall_cycles (stall_cycles),
      .errors       (errors)
   );

   always #10 clk = ~clk;

   // Memory model, low halfword is the older one
   assign fetch_word = (fetch_addr < prog_depth / 2)
                       ? {prog[2 * fetch_addr + 1], prog[2 * fetch_addr]} : '1;

   //////////////////////////////
   // Program helpers
   //////////////////////////////

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      return y ^ (y << 5);
   endfunction

   // About one in four gets a no-op opcode
   function automatic word_t random_inst(input logic [31:0] r);
      logic [4:0] op;
      op = (r[2:0] < 3'd6) ? {3'b000, r[4:3]} : (r[9:5] | 5'b00100);
      return {op, r[20:10]};
   endfunction

   function automatic word_t encode_reg(input opcode_e op, input int rd, input int rs,
                                        input int rt);
      return {op, rd[2:0], rs[2:0], 2'b00, rt[2:0]};
   endfunction

   function automatic word_t encode_imm(input opcode_e op, input int rd, input int rs,
                                        input int imm);
      return {op, rd[2:0], rs[2:0], imm[4:0]};
   endfunction

   task automatic emit(input word_t inst);
      prog[prog_len] = inst;
      prog_len++;
   endtask

   // Called on a falling edge, holds the core in reset while the program loads
   task automatic begin_test();
      rst_n    = 1'b0;
      sweep_on = 1'b0;
      prog_len = 0;
      for (int i = 0; i < prog_depth; i++) begin
         prog[i] = 16'hffff;
      end
   endtask

   task automatic finish_test(input string name, input logic need_stall);
      int unsigned errors_before;
      int unsigned fails;
      errors_before = errors;
      budget_ns     = budget_ns + (prog_len + 20) * 20;
      test_start    = 1'b1;
      @(negedge clk);
      test_start = 1'b0;
      repeat (4) @(negedge clk);
      rst_n = 1'b1;
      while (!trace_done) begin
         @(negedge clk);
      end
      sweep_on = 1'b1;
      for (int r = 0; r < 8; r++) begin
         dbg_addr = reg_idx_t'(r);
         @(negedge clk);
      end
      sweep_on = 1'b0;
      fails    = errors - errors_before;
      // Split pairs must have filled the queue at least once
      if (need_stall && stall_cycles == 0) begin
         $display("Test %0d %s: the fetch stall never went high", tests_run + 1, name);
         fails++;
      end
      tests_run++;
      if (fails == 0) begin
         $display("Test %0d %s: ok", tests_run, name);
      end else begin
         tests_failed++;
         $display("Test %0d %s: %0d errors", tests_run, name, fails);
      end
   endtask

   //////////////////////////////
   // Tests
   //////////////////////////////

   initial begin
      clk          = 1'b0;
      dbg_addr     = '0;
      test_start   = 1'b0;
      tests_run    = 0;
      tests_failed = 0;
      budget_ns    = 0;
      rng          = seed;

      begin_test();
      emit(encode_imm(op_addi, 1, 7, 5));
      emit(encode_imm(op_addi, 2, 7, -3));
      emit(encode_imm(op_addi, 3, 7, 9));
      emit(encode_imm(op_subi, 4, 7, 2));
      emit(encode_reg(op_add, 5, 1, 2));
      emit(encode_reg(op_sub, 6, 3, 4));
      emit(encode_reg(op_sub, 0, 5, 6));
      emit(encode_imm(op_addi, 1, 2, 7));
      emit(encode_reg(op_add, 2, 3, 4));
      emit(encode_imm(op_subi, 3, 5, 15));
      emit(encode_reg(op_sub, 4, 0, 1));
      emit(encode_reg(op_add, 5, 6, 2));
      finish_test("independent pairs", 1'b0);

      // Mostly split pairs, which also fills the queue
      begin_test();
      emit(encode_imm(op_addi, 1, 7, 10));
      emit(encode_imm(op_addi, 2, 1, 3));
      emit(encode_imm(op_addi, 3, 7, 4));
      emit(encode_imm(op_addi, 4, 7, 6));
      emit(encode_reg(op_sub, 5, 2, 4));
      emit(encode_imm(op_subi, 6, 5, 1));
      emit(encode_reg(op_add, 0, 6, 6));
      emit(encode_reg(op_sub, 1, 0, 3));
      emit(encode_imm(op_addi, 2, 1, -8));
      emit(encode_imm(op_addi, 3, 7, 1));
      emit(encode_reg(op_add, 4, 3, 2));
      emit(encode_reg(op_add, 4, 4, 4));
      finish_test("hazard split", 1'b1);

      begin_test();
      emit(encode_imm(op_addi, 1, 7, 3));
      emit(encode_imm(op_addi, 1, 7, 11));
      emit(encode_imm(op_addi, 2, 7, -1));
      emit(encode_reg(op_sub, 2, 7, 1));
      emit(encode_reg(op_add, 3, 1, 2));
      emit(encode_reg(op_add, 3, 2, 2));
      emit(encode_imm(op_subi, 4, 7, 6));
      emit(encode_imm(op_addi, 4, 7, 6));
      finish_test("write-write ordering", 1'b0);

      begin_test();
      emit(encode_imm(op_addi, 7, 7, 9));
      emit(encode_imm(op_addi, 1, 7, 4));
      emit(encode_reg(op_add, 7, 1, 1));
      emit(encode_reg(op_add, 2, 7, 1));
      emit(encode_reg(op_sub, 3, 7, 2));
      emit(encode_imm(op_subi, 7, 3, 1));
      emit(encode_imm(op_addi, 4, 7, -16));
      emit(encode_reg(op_add, 5, 7, 7));
      emit(encode_reg(op_sub, 6, 7, 7));
      emit(encode_imm(op_addi, 7, 6, 3));
      finish_test("zero register", 1'b0);

      begin_test();
      for (int i = 0; i < 200; i++) begin
         rng = xorshift32(rng);
         emit(random_inst(rng));
      end
      finish_test("random program", 1'b1);

      $display("Tests run %0d, passed %0d, failed %0d, check errors %0d",
               tests_run, tests_run - tests_failed, tests_failed, errors);
      if (tests_failed == 0 && errors == 0) begin
         $display("All tests passed");
      end else begin
         $display("Some tests failed");
      end
      $finish;
   end

   // Budget grows by each test's share as the test starts
   initial begin : watchdog
      wait (budget_ns != 0);
      while ($time < budget_ns) begin
         #(budget_ns - $time);
      end
      $display("Timeout: the run went past %0d ns before all tests finished", budget_ns);
      $display("Some tests failed");
      $finish;
   end

endmodule

/* tb_c16_checker.sv */
module tb_c16_checker #(
   parameter int prog_depth = 512,
   parameter int addr_width = 16
) (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  test_start,
   input  c16_pkg::word_t        prog [prog_depth],
   input  int                    prog_len,
   input  logic [addr_width-1:0] fetch_addr,
   input  logic                  fetch_stall,
   input  c16_pkg::write_port_t  wb_first,
   input  c16_pkg::write_port_t  wb_second,
   input  logic                  sweep_on,
   input  c16_pkg::reg_idx_t     dbg_addr,
   input  c16_pkg::word_t        dbg_value,
   output logic                  trace_done,
   output int unsigned           stall_cycles,
   output int unsigned           errors
);
   timeunit 1ns;
   timeprecision 1ps;
   import c16_pkg::*;

   word_t [7:0]           exp_regs;
   reg_idx_t              exp_dest [$];
   word_t                 exp_value [$];
   int unsigned           exp_count = 0;
   int unsigned           seen = 0;
   int unsigned           error_count = 0;
   int unsigned           stall_count = 0;
   reg_idx_t              wr_dest;
   word_t                 wr_value;
   logic [addr_width-1:0] exp_addr;

   // Sequential execution of one halfword, returns 1 when it writes a register
   function automatic logic model_inst(input word_t inst, input word_t [7:0] regs,
                                       output reg_idx_t dest, output word_t value);
      word_t src;
      word_t imm;
      logic  alu;
      src   = regs[inst[7:5]];
      imm   = {{11{inst[4]}}, inst[4:0]};
      dest  = inst[10:8];
      alu   = 1'b1;
      case (inst[15:11])
         5'd0: value = src + imm;
         5'd1: value = src + regs[inst[2:0]];
         5'd2: value = src - imm;
         5'd3: value = src - regs[inst[2:0]];
         default: begin
            value = '0;
            alu   = 1'b0;
         end
      endcase
      return alu && (dest != 3'd7);
   endfunction

   task automatic compare_write(input write_port_t wp);
      if (seen >= exp_count) begin
         $display("Unexpected extra write to r%0d at %0d ns", wp.dest, $time);
         error_count++;
      end else if (wp.dest != exp_dest[seen] || wp.value != exp_value[seen]) begin
         $display("CHECK FAILED at %0d ns: write %0d is r%0d = %h, expected r%0d = %h",
                  $time, seen, wp.dest, wp.value, exp_dest[seen], exp_value[seen]);
         error_count++;
      end
      seen++;
   endtask

   always @(posedge clk) begin
      if (test_start) begin
         exp_regs = '0;
         exp_dest.delete();
         exp_value.delete();
         seen        = 0;
         stall_count = 0;
         for (int i = 0; i < prog_len; i++) begin
            if (model_inst(prog[i], exp_regs, wr_dest, wr_value)) begin
               exp_regs[wr_dest] = wr_value;
               exp_dest.push_back(wr_dest);
               exp_value.push_back(wr_value);
            end
         end
         exp_count = exp_dest.size();
      end else if (rst_n) begin
         // First lane holds the older halfword of a cycle
         if (wb_first.en) begin
            compare_write(wb_first);
         end
         if (wb_second.en) begin
            compare_write(wb_second);
         end
         if (sweep_on && dbg_value != exp_regs[dbg_addr]) begin
            $display("CHECK FAILED at %0d ns: r%0d reads %h, expected %h",
                     $time, dbg_addr, dbg_value, exp_regs[dbg_addr]);
            error_count++;
         end
         if (fetch_addr != exp_addr) begin
            $display("CHECK FAILED at %0d ns: fetch address %0d, expected %0d",
                     $time, fetch_addr, exp_addr);
            error_count++;
         end
         if (fetch_stall) begin
            stall_count++;
         end
      end
      // Next fetch address, zero out of reset and held while stalled
      if (!rst_n) begin
         exp_addr = '0;
      end else if (fetch_stall) begin
         exp_addr = fetch_addr;
      end else begin
         exp_addr = fetch_addr + 1'b1;
      end
   end

   assign trace_done   = (seen >= exp_count);
   assign stall_cycles = stall_count;
   assign errors       = error_count;

endmodule
